// File: verilog/display_defs.svh
`ifndef DISPLAY_DEFS_SVH
`define DISPLAY_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// frame geometry
////////////////////////////////////////////////////////////////////////////

// default visible area in pixels
`define DISPLAY_AREA_H 640
`define DISPLAY_AREA_V 480

////////////////////////////////////////////////////////////////////////////
// pixel memory
////////////////////////////////////////////////////////////////////////////

// one word per pixel, linear address y*H+x
// 19 bits covers 640x480
`define DISPLAY_ADDR_W 19

`endif

// File: verilog/display_cmd_pkg.sv
package display_cmd_pkg;

	// host opcode in bits 31:30 of every command word
	typedef enum logic [1:0] {
		COLOR   = 2'd0,
		CLEAR   = 2'd1,
		PLOT    = 2'd2,
		ILLEGAL = 2'd3
	} cmd_op_e;

	// COLOR and CLEAR carry an rgb value
	typedef struct packed {
		cmd_op_e     op;
		logic [5:0]  rsvd;
		logic [23:0] rgb;
	} cmd_color_view_t;

	// PLOT carries a coordinate pair
	typedef struct packed {
		cmd_op_e     op;
		logic        rsvd;
		logic [9:0]  x;
		logic [8:0]  y;
		logic [9:0]  spare;
	} cmd_point_view_t;

	typedef union packed {
		cmd_color_view_t color;
		cmd_point_view_t point;
	} cmd_word_u;

	typedef struct packed {
		cmd_op_e     op;
		logic [23:0] color;
		logic [9:0]  x;
		logic [8:0]  y;
		logic        illegal;
	} cmd_decoded_t;

endpackage

// File: verilog/display_mem_pkg.sv
package display_mem_pkg;

	`include "display_defs.svh"

	// packed in memory order, r in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_rgb_t;

	// one entry of the stream between sequencer and write port
	// we low means no memory access, only completion bookkeeping
	typedef struct packed {
		logic                       we;
		logic [`DISPLAY_ADDR_W-1:0] addr;
		pixel_rgb_t                 rgb;
		logic                       last;
		logic                       err;
	} pix_write_t;

endpackage

// File: verilog/display_cmd_decoder.sv
`timescale 1ns/1ps

module display_cmd_decoder (
	input  logic                          iCLOCK,
	input  logic                          inRESET,
	input  logic                          reset_sync,
	input  logic                          cmd_valid,
	input  display_cmd_pkg::cmd_word_u    cmd_word,
	input  logic                          done,
	output logic                          busy,
	output logic                          dec_valid,
	output display_cmd_pkg::cmd_decoded_t dec_cmd
);
	import display_cmd_pkg::*;

	cmd_word_u   cmd_q;
	logic [23:0] plot_color;
	logic        accept;

	// a strobe while busy is dropped
	assign accept = cmd_valid && !busy;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			busy       <= 1'b0;
			dec_valid  <= 1'b0;
			plot_color <= 24'h0;
		end else if (reset_sync) begin
			busy       <= 1'b0;
			dec_valid  <= 1'b0;
			plot_color <= 24'h0;
		end else begin
			dec_valid <= accept;
			if (accept) begin
				busy <= 1'b1;
			end else if (done) begin
				busy <= 1'b0;
			end
			// latched for later PLOTs
			if (accept && cmd_word.color.op == COLOR) begin
				plot_color <= cmd_word.color.rgb;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			cmd_q <= cmd_word;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// decode through the view picked by the opcode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		dec_cmd         = '0;
		dec_cmd.op      = cmd_q.color.op;
		dec_cmd.illegal = 1'b0;
		case (cmd_q.color.op)
			COLOR, CLEAR: begin
				dec_cmd.color = cmd_q.color.rgb;
			end
			PLOT: begin
				dec_cmd.color = plot_color;
				dec_cmd.x     = cmd_q.point.x;
				dec_cmd.y     = cmd_q.point.y;
			end
			default: begin
				dec_cmd.illegal = 1'b1;
			end
		endcase
	end

endmodule

// File: verilog/display_fill_sequencer.sv
`timescale 1ns/1ps

`include "display_defs.svh"

module display_fill_sequencer #(
	parameter int AREA_H = `DISPLAY_AREA_H,
	parameter int AREA_V = `DISPLAY_AREA_V
) (
	input  logic                          iCLOCK,
	input  logic                          inRESET,
	input  logic                          reset_sync,
	input  logic                          dec_valid,
	input  display_cmd_pkg::cmd_decoded_t dec_cmd,
	input  logic                          wr_ready,
	output logic                          wr_valid,
	output display_mem_pkg::pix_write_t   wr_item
);
	import display_cmd_pkg::*;
	import display_mem_pkg::*;

	localparam int ADDR_W = `DISPLAY_ADDR_W;
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(AREA_H * AREA_V - 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_FILL,
		S_SINGLE
	} state_e;

	state_e            state;
	logic [ADDR_W-1:0] addr_q;
	logic [ADDR_W-1:0] plot_addr;
	pixel_rgb_t        rgb_q;
	logic              we_q;
	logic              err_q;
	logic              in_range;
	logic              is_last;

	assign in_range  = (int'(dec_cmd.x) < AREA_H) && (int'(dec_cmd.y) < AREA_V);
	assign plot_addr = ADDR_W'(dec_cmd.y) * ADDR_W'(AREA_H) + ADDR_W'(dec_cmd.x);

	////////////////////////////////////////////////////////////////////////////
	// state machine and address counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state  <= S_IDLE;
			addr_q <= '0;
			we_q   <= 1'b0;
			err_q  <= 1'b0;
		end else if (reset_sync) begin
			state  <= S_IDLE;
			addr_q <= '0;
			we_q   <= 1'b0;
			err_q  <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (dec_valid) begin
						addr_q <= '0;
						we_q   <= 1'b0;
						err_q  <= dec_cmd.illegal;
						case (dec_cmd.op)
							CLEAR: begin
								state <= S_FILL;
								we_q  <= 1'b1;
							end
							PLOT: begin
								state <= S_SINGLE;
								if (in_range) begin
									we_q   <= 1'b1;
									addr_q <= plot_addr;
								end else begin
									err_q <= 1'b1;
								end
							end
							// COLOR and illegal only report completion
							default: begin
								state <= S_SINGLE;
							end
						endcase
					end
				end
				S_FILL: begin
					if (wr_ready) begin
						if (is_last) begin
							state <= S_IDLE;
						end else begin
							addr_q <= addr_q + 1'b1;
						end
					end
				end
				S_SINGLE: begin
					if (wr_ready) begin
						state <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (state == S_IDLE && dec_valid) begin
			rgb_q <= pixel_rgb_t'(dec_cmd.color);
		end
	end

	assign is_last  = (state == S_SINGLE) || (addr_q == LAST_ADDR);
	assign wr_valid = (state != S_IDLE);
	assign wr_item  = '{we: we_q, addr: addr_q, rgb: rgb_q, last: is_last, err: err_q};

endmodule

// File: verilog/display_write_port.sv
`timescale 1ns/1ps

`include "display_defs.svh"

module display_write_port (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             reset_sync,
	input  logic                             wr_valid,
	input  display_mem_pkg::pix_write_t      wr_item,
	input  logic                             mem_busy,
	output logic                             wr_ready,
	output logic                             mem_valid,
	output logic [`DISPLAY_ADDR_W-1:0]       mem_addr,
	output display_mem_pkg::pixel_rgb_t      mem_data,
	output logic                             finish,
	output logic                             cmd_error
);
	import display_mem_pkg::*;

	pix_write_t out_item;
	pix_write_t skid_item;
	pix_write_t next_item;
	logic       out_valid;
	logic       skid_valid;
	logic       skid_next;
	logic       wr_fire;
	logic       mem_fire;
	logic       out_free;
	logic       src_valid;
	logic       load_out;
	logic       retire;

	assign wr_fire   = wr_valid && wr_ready;
	assign mem_fire  = out_valid && !mem_busy;
	// output register empties or moves on this cycle
	assign out_free  = !out_valid || !mem_busy;
	// skid entry is always older than the incoming item
	assign src_valid = skid_valid || wr_fire;
	assign next_item = skid_valid ? skid_item : wr_item;
	assign load_out  = out_free && src_valid && next_item.we;
	assign retire    = out_free && src_valid && !next_item.we;
	assign skid_next = !out_free && src_valid;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
			wr_ready   <= 1'b1;
			finish     <= 1'b0;
			cmd_error  <= 1'b0;
		end else if (reset_sync) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
			wr_ready   <= 1'b1;
			finish     <= 1'b0;
			cmd_error  <= 1'b0;
		end else begin
			if (load_out) begin
				out_valid <= 1'b1;
			end else if (mem_fire) begin
				out_valid <= 1'b0;
			end
			skid_valid <= skid_next;
			wr_ready   <= !skid_next;
			finish     <= (mem_fire && out_item.last) || (retire && next_item.last);
			cmd_error  <= (mem_fire && out_item.last && out_item.err)
				|| (retire && next_item.last && next_item.err);
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (load_out) begin
			out_item <= next_item;
		end
		if (wr_fire && !out_free) begin
			skid_item <= wr_item;
		end
	end

	assign mem_valid = out_valid;
	assign mem_addr  = out_item.addr;
	assign mem_data  = out_item.rgb;

endmodule

// File: verilog/display_pipeline_top.sv
`timescale 1ns/1ps

`include "display_defs.svh"

module display_pipeline_top #(
	parameter int AREA_H = `DISPLAY_AREA_H,
	parameter int AREA_V = `DISPLAY_AREA_V
) (
	input  logic                          iCLOCK,
	input  logic                          inRESET,
	input  logic                          reset_sync,
	input  logic                          cmd_valid,
	input  display_cmd_pkg::cmd_word_u    cmd_word,
	input  logic                          mem_busy,
	output logic                          busy,
	output logic                          finish,
	output logic                          cmd_error,
	output logic                          mem_valid,
	output logic [`DISPLAY_ADDR_W-1:0]    mem_addr,
	output display_mem_pkg::pixel_rgb_t   mem_data
);
	import display_cmd_pkg::*;
	import display_mem_pkg::*;

	logic         dec_valid;
	cmd_decoded_t dec_cmd;
	logic         wr_valid;
	logic         wr_ready;
	pix_write_t   wr_item;

	////////////////////////////////////////////////////////////////////////////
	// decode -> sequence -> memory write
	////////////////////////////////////////////////////////////////////////////

	display_cmd_decoder u_decoder (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.reset_sync (reset_sync),
		.cmd_valid  (cmd_valid),
		.cmd_word   (cmd_word),
		.done       (finish),
		.busy       (busy),
		.dec_valid  (dec_valid),
		.dec_cmd    (dec_cmd)
	);

	display_fill_sequencer #(
		.AREA_H (AREA_H),
		.AREA_V (AREA_V)
	) u_sequencer (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.reset_sync (reset_sync),
		.dec_valid  (dec_valid),
		.dec_cmd    (dec_cmd),
		.wr_ready   (wr_ready),
		.wr_valid   (wr_valid),
		.wr_item    (wr_item)
	);

	display_write_port u_write_port (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.reset_sync (reset_sync),
		.wr_valid   (wr_valid),
		.wr_item    (wr_item),
		.mem_busy   (mem_busy),
		.wr_ready   (wr_ready),
		.mem_valid  (mem_valid),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.finish     (finish),
		.cmd_error  (cmd_error)
	);

endmodule

// File: testbench/display_pipeline_sva.sv
`timescale 1ns/1ps

`include "display_defs.svh"

module display_pipeline_sva (
	input logic                        iCLOCK,
	input logic                        inRESET,
	input logic                        reset_sync,
	input logic                        mem_busy,
	input logic                        mem_valid,
	input logic [`DISPLAY_ADDR_W-1:0]  mem_addr,
	input display_mem_pkg::pixel_rgb_t mem_data,
	input logic                        finish,
	input logic                        cmd_error
);
	int fail_count = 0;

	// a soft reset may clear the port while memory is still busy
	mem_hold_a: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_valid && mem_busy && !reset_sync |=>
			mem_valid && $stable(mem_addr) && $stable(mem_data))
	else begin
		$error("memory outputs moved while mem_busy was high");
		fail_count++;
	end

	finish_pulse_a: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		finish |=> !finish)
	else begin
		$error("finish stayed high for more than one cycle");
		fail_count++;
	end

	error_pulse_a: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		cmd_error |=> !cmd_error)
	else begin
		$error("cmd_error stayed high for more than one cycle");
		fail_count++;
	end

	error_with_finish_a: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		cmd_error |-> finish)
	else begin
		$error("cmd_error pulsed without finish");
		fail_count++;
	end

endmodule

bind display_pipeline_top display_pipeline_sva u_sva (
	.iCLOCK     (iCLOCK),
	.inRESET    (inRESET),
	.reset_sync (reset_sync),
	.mem_busy   (mem_busy),
	.mem_valid  (mem_valid),
	.mem_addr   (mem_addr),
	.mem_data   (mem_data),
	.finish     (finish),
	.cmd_error  (cmd_error)
);

// File: testbench/display_checker.sv
`timescale 1ns/1ps

`include "display_defs.svh"

module display_checker #(
	parameter int AREA_H = 16,
	parameter int AREA_V = 8
) (
	input  logic                        iCLOCK,
	input  logic                        inRESET,
	input  logic                        reset_sync,
	input  logic                        cmd_valid,
	input  display_cmd_pkg::cmd_word_u  cmd_word,
	input  logic                        busy,
	input  logic                        finish,
	input  logic                        cmd_error,
	input  logic                        mem_valid,
	input  logic                        mem_busy,
	input  logic [`DISPLAY_ADDR_W-1:0]  mem_addr,
	input  display_mem_pkg::pixel_rgb_t mem_data,
	output int                          error_count,
	output int                          write_count,
	output logic                        idle
);
	import display_cmd_pkg::*;
	import display_mem_pkg::*;

	typedef struct packed {
		logic [`DISPLAY_ADDR_W-1:0] addr;
		pixel_rgb_t                 rgb;
	} mem_write_t;

	mem_write_t  expect_q[$];
	logic [23:0] model_color;
	logic        active;
	logic        was_active;
	logic        expect_err;

	////////////////////////////////////////////////////////////////////////////
	// reference model of one command
	////////////////////////////////////////////////////////////////////////////

	task automatic predict_command(input cmd_word_u w);
		int         a;
		int         px;
		int         py;
		mem_write_t item;
		px = int'(w.point.x);
		py = int'(w.point.y);
		expect_err = 1'b0;
		case (w.color.op)
			COLOR: begin
				model_color = w.color.rgb;
			end
			CLEAR: begin
				for (a = 0; a < AREA_H * AREA_V; a++) begin
					item.addr = `DISPLAY_ADDR_W'(a);
					item.rgb  = pixel_rgb_t'(w.color.rgb);
					expect_q.push_back(item);
				end
			end
			PLOT: begin
				if (px < AREA_H && py < AREA_V) begin
					item.addr = `DISPLAY_ADDR_W'(py * AREA_H + px);
					item.rgb  = pixel_rgb_t'(model_color);
					expect_q.push_back(item);
				end else begin
					expect_err = 1'b1;
				end
			end
			default: begin
				expect_err = 1'b1;
			end
		endcase
	endtask

	task automatic compare_write();
		mem_write_t want;
		write_count++;
		if (expect_q.size() == 0) begin
			$display("unexpected memory write to address %h at %0t", mem_addr, $time);
			error_count++;
		end else begin
			want = expect_q.pop_front();
			if (mem_addr !== want.addr) begin
				$display("ERROR: mem_addr expected %h got %h at %0t",
					want.addr, mem_addr, $time);
				error_count++;
			end
			if (mem_data !== want.rgb) begin
				$display("ERROR: mem_data expected %h got %h at %0t",
					want.rgb, mem_data, $time);
				error_count++;
			end
		end
	endtask

	task automatic close_command();
		if (!active) begin
			$display("finish pulsed with no command in flight at %0t", $time);
			error_count++;
		end else begin
			if (expect_q.size() != 0) begin
				$display("command finished with %0d writes never made at %0t",
					expect_q.size(), $time);
				error_count++;
			end
			if (cmd_error !== expect_err) begin
				$display("ERROR: cmd_error expected %h got %h at %0t",
					expect_err, cmd_error, $time);
				error_count++;
			end
		end
		active = 1'b0;
		expect_q.delete();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// per cycle comparison
	////////////////////////////////////////////////////////////////////////////

	always @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			expect_q.delete();
			model_color = 24'h0;
			active      = 1'b0;
			was_active  = 1'b0;
			expect_err  = 1'b0;
			error_count = 0;
			write_count = 0;
			idle        = 1'b1;
		end else begin
			// busy still holds through the finish cycle
			was_active = active;
			if (busy !== active) begin
				$display("ERROR: busy expected %h got %h at %0t", active, busy, $time);
				error_count++;
			end
			if (mem_valid && !mem_busy) begin
				compare_write();
			end
			if (finish) begin
				close_command();
			end else if (cmd_error) begin
				$display("cmd_error pulsed without finish at %0t", $time);
				error_count++;
			end
			// abort drops the command in flight and the plot color
			if (reset_sync) begin
				expect_q.delete();
				active      = 1'b0;
				model_color = 24'h0;
			end else if (cmd_valid && !was_active) begin
				predict_command(cmd_word);
				active = 1'b1;
			end
			idle = !active && (expect_q.size() == 0);
		end
	end

endmodule

// File: testbench/tb_display_pipeline.sv
`timescale 1ns/1ps

`include "display_defs.svh"

module tb_display_pipeline;
	import display_cmd_pkg::*;
	import display_mem_pkg::*;

	localparam int AREA_H       = 16;
	localparam int AREA_V       = 8;
	localparam int NUM_CMDS     = 12;
	localparam int RESET_CYCLES = 4;
	// four full frames per table entry, plus the reset
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_CMDS * (AREA_H * AREA_V + 10) * 4;

	// abort_at counts cycles after the busy decoy, 0 means run to completion
	typedef struct packed {
		logic [31:0] word;
		logic [7:0]  abort_at;
	} cmd_entry_t;

	logic                       iCLOCK = 1'b0;
	logic                       inRESET;
	logic                       reset_sync;
	logic                       cmd_valid;
	cmd_word_u                  cmd_word;
	logic                       mem_busy = 1'b0;
	logic                       busy;
	logic                       finish;
	logic                       cmd_error;
	logic                       mem_valid;
	logic [`DISPLAY_ADDR_W-1:0] mem_addr;
	pixel_rgb_t                 mem_data;
	cmd_entry_t                 cmd_table [NUM_CMDS];
	int                         seed = 32'hc619b325;
	int                         check_errors;
	int                         write_count;
	logic                       checker_idle;
	int                         tb_errors;
	int                         total_errors;
	int                         idx;

	display_pipeline_top #(
		.AREA_H (AREA_H),
		.AREA_V (AREA_V)
	) uut (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.reset_sync (reset_sync),
		.cmd_valid  (cmd_valid),
		.cmd_word   (cmd_word),
		.mem_busy   (mem_busy),
		.busy       (busy),
		.finish     (finish),
		.cmd_error  (cmd_error),
		.mem_valid  (mem_valid),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data)
	);

	display_checker #(
		.AREA_H (AREA_H),
		.AREA_V (AREA_V)
	) u_checker (
		.iCLOCK      (iCLOCK),
		.inRESET     (inRESET),
		.reset_sync  (reset_sync),
		.cmd_valid   (cmd_valid),
		.cmd_word    (cmd_word),
		.busy        (busy),
		.finish      (finish),
		.cmd_error   (cmd_error),
		.mem_valid   (mem_valid),
		.mem_busy    (mem_busy),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.error_count (check_errors),
		.write_count (write_count),
		.idle        (checker_idle)
	);

	always #50 iCLOCK = ~iCLOCK;

	// memory back-pressure, busy about one cycle in four
	always @(posedge iCLOCK) begin
		#5;
		mem_busy = (($random(seed) & 3) == 0);
	end

	function automatic logic [31:0] rgb_cmd(input cmd_op_e op, input logic [23:0] rgb);
		cmd_word_u w;
		w           = '0;
		w.color.op  = op;
		w.color.rgb = rgb;
		return w;
	endfunction

	function automatic logic [31:0] plot_cmd(input logic [9:0] x, input logic [8:0] y);
		cmd_word_u w;
		w          = '0;
		w.point.op = PLOT;
		w.point.x  = x;
		w.point.y  = y;
		return w;
	endfunction

	task automatic wait_idle();
		while (busy !== 1'b0) begin
			@(posedge iCLOCK);
			#5;
		end
	endtask

	task automatic run_entry(input cmd_entry_t e);
		wait_idle();
		cmd_valid = 1'b1;
		cmd_word  = e.word;
		@(posedge iCLOCK);
		#5;
		cmd_valid = 1'b0;
		@(posedge iCLOCK);
		#5;
		// offered while busy, a changed plot color would show up later
		cmd_valid = 1'b1;
		cmd_word  = rgb_cmd(COLOR, 24'hdead00);
		@(posedge iCLOCK);
		#5;
		cmd_valid = 1'b0;
		if (e.abort_at != 8'd0) begin
			repeat (e.abort_at) @(posedge iCLOCK);
			#5;
			reset_sync = 1'b1;
			@(posedge iCLOCK);
			#5;
			reset_sync = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// command table and stimulus loop
	////////////////////////////////////////////////////////////////////////////

	initial begin
		inRESET    = 1'b0;
		reset_sync = 1'b0;
		cmd_valid  = 1'b0;
		cmd_word   = '0;
		tb_errors  = 0;
		cmd_table[0]  = '{rgb_cmd(CLEAR, 24'h112233), 8'd0};
		cmd_table[1]  = '{rgb_cmd(COLOR, 24'ha0b0c0), 8'd0};
		cmd_table[2]  = '{plot_cmd(10'd3, 9'd5), 8'd0};
		cmd_table[3]  = '{plot_cmd(10'd15, 9'd7), 8'd0};
		cmd_table[4]  = '{plot_cmd(10'd16, 9'd0), 8'd0};
		cmd_table[5]  = '{plot_cmd(10'd0, 9'd8), 8'd0};
		cmd_table[6]  = '{32'hc0ab_cdef, 8'd0};
		cmd_table[7]  = '{rgb_cmd(CLEAR, 24'h445566), 8'd20};
		cmd_table[8]  = '{plot_cmd(10'd7, 9'd2), 8'd0};
		cmd_table[9]  = '{rgb_cmd(COLOR, 24'h0f0e0d), 8'd0};
		cmd_table[10] = '{rgb_cmd(CLEAR, 24'hffffff), 8'd0};
		cmd_table[11] = '{plot_cmd(10'd0, 9'd0), 8'd0};
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		#5;
		inRESET = 1'b1;
		for (idx = 0; idx < NUM_CMDS; idx++) begin
			run_entry(cmd_table[idx]);
		end
		wait_idle();
		repeat (4) @(posedge iCLOCK);
		if (!checker_idle) begin
			$display("run ended with a command or expected writes still outstanding");
			tb_errors++;
		end
		total_errors = check_errors + uut.u_sva.fail_count + tb_errors;
		$display("errors: checker %0d, assertions %0d, testbench %0d (%0d writes seen)",
			check_errors, uut.u_sva.fail_count, tb_errors, write_count);
		if (total_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge iCLOCK);
		$display("watchdog expired after %0d cycles, the command table did not complete",
			TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: files.f
+incdir+verilog
verilog/display_cmd_pkg.sv
verilog/display_mem_pkg.sv
verilog/display_cmd_decoder.sv
verilog/display_fill_sequencer.sv
verilog/display_write_port.sv
verilog/display_pipeline_top.sv
testbench/display_pipeline_sva.sv
testbench/display_checker.sv
testbench/tb_display_pipeline.sv

// File: Makefile
SHELL     := /bin/bash

VERILATOR ?= verilator
TOP       ?= tb_display_pipeline
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= STATUS: FAIL

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	set -o pipefail; ./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
